// ==== rtl/board_pkg.sv ====
// Word and address widths, board ID, command byte fields and register map
package board_pkg;

// One register word and also one serial byte
localparam int REG_W = 8;
localparam int ADDR_W = 4;

// Constant returned by the ID register
localparam logic [REG_W-1:0] BOARD_ID = 8'h5a;

// Write flag sits in the top bit of the command byte
localparam int CMD_WRITE_BIT = 7;

// Address field starts at bit 0
localparam int CMD_ADDR_LSB = 0;

// Register map
localparam logic [ADDR_W-1:0] ADDR_ID           = 4'd0;
localparam logic [ADDR_W-1:0] ADDR_SW           = 4'd1;
localparam logic [ADDR_W-1:0] ADDR_LED          = 4'd2;
localparam logic [ADDR_W-1:0] ADDR_PORT_LPMODE  = 4'd3;
localparam logic [ADDR_W-1:0] ADDR_PORT_SEL     = 4'd4;
localparam logic [ADDR_W-1:0] ADDR_PORT_RESET   = 4'd5;
localparam logic [ADDR_W-1:0] ADDR_PORT_PRESENT = 4'd6;
localparam logic [ADDR_W-1:0] ADDR_PORT_INT     = 4'd7;

endpackage

// ==== rtl/debounce_switch.sv ====
// Switch debouncer with divided sample rate and per-bit sample history
module debounce_switch #(
    parameter int SW_CNT = 4,
    parameter int DEBOUNCE_RATE = 4,
    parameter int DEBOUNCE_N = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [SW_CNT-1:0] sw_in,
    output logic      [SW_CNT-1:0] sw_out
);

localparam int RATE_W = $clog2(DEBOUNCE_RATE + 1);
localparam logic [RATE_W-1:0] RATE_END = RATE_W'(DEBOUNCE_RATE - 1);

logic [RATE_W-1:0] rate_cnt;

// Last DEBOUNCE_N samples of each switch with the newest in bit 0
logic [SW_CNT-1:0][DEBOUNCE_N-1:0] hist;

always_ff @(posedge clk) begin
    if (reset) begin
        rate_cnt <= '0;
        hist <= '0;
        sw_out <= '0;
    end else begin
        if (rate_cnt == RATE_END) begin
            rate_cnt <= '0;
            for (int i = 0; i < SW_CNT; i++) begin
                hist[i] <= {hist[i][DEBOUNCE_N-2:0], sw_in[i]};
            end
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end

        // Output only moves once the whole history agrees
        for (int i = 0; i < SW_CNT; i++) begin
            if (&hist[i]) begin
                sw_out[i] <= 1'b1;
            end else if (~|hist[i]) begin
                sw_out[i] <= 1'b0;
            end
        end
    end
end

endmodule

// ==== rtl/uart_rx.sv ====
// 8N1 UART receiver with input synchronizer and stop bit check
module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          rxd,
    output logic      [board_pkg::REG_W-1:0]   rx_data,
    output logic                               rx_valid
);

localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_START = 2'd1;
localparam logic [1:0] ST_DATA = 2'd2;
localparam logic [1:0] ST_STOP = 2'd3;

logic [1:0] rxd_sync;
logic [1:0] state;
logic [CNT_W-1:0] clk_cnt;
logic [2:0] bit_idx;
logic [board_pkg::REG_W-1:0] shift;

always_ff @(posedge clk) begin
    if (reset) begin
        rxd_sync <= 2'b11;
        state <= ST_IDLE;
        clk_cnt <= '0;
        bit_idx <= '0;
        rx_valid <= 1'b0;
    end else begin
        rxd_sync <= {rxd_sync[0], rxd};
        rx_valid <= 1'b0;
        clk_cnt <= clk_cnt + 1'b1;
        case (state)
            ST_IDLE: begin
                clk_cnt <= '0;
                if (!rxd_sync[1]) begin
                    state <= ST_START;
                end
            end
            ST_START: begin
                // Line must still be low half a bit in
                if (clk_cnt == HALF_END) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state <= rxd_sync[1] ? ST_IDLE : ST_DATA;
                end
            end
            ST_DATA: begin
                if (clk_cnt == BIT_END) begin
                    clk_cnt <= '0;
                    shift <= {rxd_sync[1], shift[board_pkg::REG_W-1:1]};
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= ST_STOP;
                    end
                end
            end
            default: begin
                if (clk_cnt == BIT_END) begin
                    // Framing error drops the byte silently
                    rx_valid <= rxd_sync[1];
                    rx_data <= shift;
                    state <= ST_IDLE;
                end
            end
        endcase
    end
end

endmodule

// ==== rtl/uart_tx.sv ====
// 8N1 UART transmitter with start strobe and busy flag
module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [board_pkg::REG_W-1:0]   tx_data,
    input  wire logic                          tx_start,
    output logic                               txd,
    output logic                               tx_busy
);

localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

logic [CNT_W-1:0] clk_cnt;
logic [3:0] bit_cnt;

// Data bits followed by the stop bit
logic [board_pkg::REG_W:0] shift;

always_ff @(posedge clk) begin
    if (reset) begin
        txd <= 1'b1;
        tx_busy <= 1'b0;
        clk_cnt <= '0;
        bit_cnt <= '0;
    end else if (!tx_busy) begin
        if (tx_start) begin
            shift <= {1'b1, tx_data};
            txd <= 1'b0;
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end
    end else if (clk_cnt == BIT_END) begin
        clk_cnt <= '0;
        if (bit_cnt == 4'd9) begin
            // End of stop bit
            tx_busy <= 1'b0;
        end else begin
            txd <= shift[0];
            shift <= shift >> 1;
            bit_cnt <= bit_cnt + 1'b1;
        end
    end else begin
        clk_cnt <= clk_cnt + 1'b1;
    end
end

endmodule

// ==== rtl/mgmt_cmd.sv ====
// Command frame parser driving one four-phase register access per command
module mgmt_cmd (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [board_pkg::REG_W-1:0]    rx_data,
    input  wire logic                           rx_valid,
    output logic                                reg_req,
    output logic                                reg_we,
    output logic      [board_pkg::ADDR_W-1:0]   reg_addr,
    output logic      [board_pkg::REG_W-1:0]    reg_wdata,
    input  wire logic                           reg_ack,
    input  wire logic [board_pkg::REG_W-1:0]    reg_rdata,
    output logic      [board_pkg::REG_W-1:0]    tx_data,
    output logic                                tx_start,
    input  wire logic                           tx_busy
);

localparam logic [2:0] ST_IDLE = 3'd0;
localparam logic [2:0] ST_DATA = 3'd1;
localparam logic [2:0] ST_REQ = 3'd2;
localparam logic [2:0] ST_ACK_FALL = 3'd3;
localparam logic [2:0] ST_SEND = 3'd4;
localparam logic [2:0] ST_TX_WAIT = 3'd5;

logic [2:0] state;

always_ff @(posedge clk) begin
    if (reset) begin
        state <= ST_IDLE;
        reg_req <= 1'b0;
        reg_we <= 1'b0;
        tx_start <= 1'b0;
    end else begin
        tx_start <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (rx_valid) begin
                    reg_addr <= rx_data[board_pkg::CMD_ADDR_LSB +: board_pkg::ADDR_W];
                    reg_we <= rx_data[board_pkg::CMD_WRITE_BIT];
                    if (rx_data[board_pkg::CMD_WRITE_BIT]) begin
                        state <= ST_DATA;
                    end else begin
                        // Read frame is complete so the access starts
                        reg_req <= 1'b1;
                        state <= ST_REQ;
                    end
                end
            end
            ST_DATA: begin
                if (rx_valid) begin
                    reg_wdata <= rx_data;
                    reg_req <= 1'b1;
                    state <= ST_REQ;
                end
            end
            ST_REQ: begin
                if (reg_ack) begin
                    tx_data <= reg_rdata;
                    tx_start <= 1'b1;
                    reg_req <= 1'b0;
                    state <= ST_ACK_FALL;
                end
            end
            ST_ACK_FALL: begin
                // Finish the handshake before anything else
                if (!reg_ack) begin
                    state <= ST_SEND;
                end
            end
            ST_SEND: begin
                // Transmitter has taken the response byte
                if (tx_busy) begin
                    state <= ST_TX_WAIT;
                end
            end
            ST_TX_WAIT: begin
                if (!tx_busy) begin
                    state <= ST_IDLE;
                end
            end
            default: begin
                state <= ST_IDLE;
            end
        endcase
    end
end

endmodule

// ==== rtl/mgmt_regs.sv ====
// Register block for ID, switches, LEDs and QSFP port control and status
module mgmt_regs #(
    parameter int SW_CNT = 4,
    parameter int LED_CNT = 3,
    parameter int PORT_CNT = 2
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           reg_req,
    input  wire logic                           reg_we,
    input  wire logic [board_pkg::ADDR_W-1:0]   reg_addr,
    input  wire logic [board_pkg::REG_W-1:0]    reg_wdata,
    output logic                                reg_ack,
    output logic      [board_pkg::REG_W-1:0]    reg_rdata,
    input  wire logic [SW_CNT-1:0]              sw_state,
    output logic      [LED_CNT-1:0]             led,
    output logic      [PORT_CNT-1:0]            port_lpmode,
    output logic      [PORT_CNT-1:0]            port_sel,
    output logic      [PORT_CNT-1:0]            port_reset_start,
    input  wire logic [PORT_CNT-1:0]            port_in_reset,
    input  wire logic [PORT_CNT-1:0]            port_present,
    input  wire logic [PORT_CNT-1:0]            port_int
);

logic access;
logic wr;
logic [LED_CNT-1:0] led_next;
logic [PORT_CNT-1:0] lpmode_next;
logic [PORT_CNT-1:0] sel_next;
logic [PORT_CNT-1:0] reset_mask;
logic [board_pkg::REG_W-1:0] rd_word;

// Exactly one access per request
assign access = reg_req && !reg_ack;
assign wr = access && reg_we;

always_comb begin
    led_next = led;
    lpmode_next = port_lpmode;
    sel_next = port_sel;
    reset_mask = '0;
    if (wr) begin
        case (reg_addr)
            board_pkg::ADDR_LED: led_next = reg_wdata[LED_CNT-1:0];
            board_pkg::ADDR_PORT_LPMODE: lpmode_next = reg_wdata[PORT_CNT-1:0];
            board_pkg::ADDR_PORT_SEL: sel_next = reg_wdata[PORT_CNT-1:0];
            board_pkg::ADDR_PORT_RESET: reset_mask = reg_wdata[PORT_CNT-1:0];
            default: ;
        endcase
    end
end

// Read word reflects the state after a write in the same access
always_comb begin
    case (reg_addr)
        board_pkg::ADDR_ID: rd_word = board_pkg::BOARD_ID;
        board_pkg::ADDR_SW: rd_word = board_pkg::REG_W'(sw_state);
        board_pkg::ADDR_LED: rd_word = board_pkg::REG_W'(led_next);
        board_pkg::ADDR_PORT_LPMODE: rd_word = board_pkg::REG_W'(lpmode_next);
        board_pkg::ADDR_PORT_SEL: rd_word = board_pkg::REG_W'(sel_next);
        board_pkg::ADDR_PORT_RESET: rd_word = board_pkg::REG_W'(port_in_reset | reset_mask);
        board_pkg::ADDR_PORT_PRESENT: rd_word = board_pkg::REG_W'(port_present);
        board_pkg::ADDR_PORT_INT: rd_word = board_pkg::REG_W'(port_int);
        default: rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        led <= '0;
        port_lpmode <= '0;
        port_sel <= '0;
        port_reset_start <= '0;
        reg_ack <= 1'b0;
    end else begin
        led <= led_next;
        port_lpmode <= lpmode_next;
        port_sel <= sel_next;
        port_reset_start <= reset_mask;
        if (access) begin
            reg_ack <= 1'b1;
            reg_rdata <= rd_word;
        end else if (!reg_req) begin
            reg_ack <= 1'b0;
        end
    end
end

endmodule

// ==== rtl/qsfp_port_ctrl.sv ====
// QSFP reset pulse timers, status synchronizers and active-low pin drivers
module qsfp_port_ctrl #(
    parameter int PORT_CNT = 2,
    parameter int RESET_CYCLES = 20
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [PORT_CNT-1:0] port_lpmode,
    input  wire logic [PORT_CNT-1:0] port_sel,
    input  wire logic [PORT_CNT-1:0] port_reset_start,
    output logic      [PORT_CNT-1:0] port_in_reset,
    output logic      [PORT_CNT-1:0] port_present,
    output logic      [PORT_CNT-1:0] port_int,
    output logic      [PORT_CNT-1:0] qsfp_modsell,
    output logic      [PORT_CNT-1:0] qsfp_resetl,
    output logic      [PORT_CNT-1:0] qsfp_lpmode,
    input  wire logic [PORT_CNT-1:0] qsfp_modprsl,
    input  wire logic [PORT_CNT-1:0] qsfp_intl
);

localparam int CNT_W = $clog2(RESET_CYCLES + 1);

// Cycles of reset left per port
logic [PORT_CNT-1:0][CNT_W-1:0] rst_cnt;

logic [PORT_CNT-1:0] modprsl_meta;
logic [PORT_CNT-1:0] modprsl_sync;
logic [PORT_CNT-1:0] intl_meta;
logic [PORT_CNT-1:0] intl_sync;

always_ff @(posedge clk) begin
    if (reset) begin
        rst_cnt <= '0;
        modprsl_meta <= '1;
        modprsl_sync <= '1;
        intl_meta <= '1;
        intl_sync <= '1;
    end else begin
        for (int p = 0; p < PORT_CNT; p++) begin
            // A new start reloads the full count
            if (port_reset_start[p]) begin
                rst_cnt[p] <= CNT_W'(RESET_CYCLES);
            end else if (rst_cnt[p] != '0) begin
                rst_cnt[p] <= rst_cnt[p] - 1'b1;
            end
        end
        modprsl_meta <= qsfp_modprsl;
        modprsl_sync <= modprsl_meta;
        intl_meta <= qsfp_intl;
        intl_sync <= intl_meta;
    end
end

always_comb begin
    for (int p = 0; p < PORT_CNT; p++) begin
        port_in_reset[p] = (rst_cnt[p] != '0);
    end
end

assign qsfp_resetl = ~port_in_reset;
assign qsfp_modsell = ~port_sel;
assign qsfp_lpmode = port_lpmode;
assign port_present = ~modprsl_sync;
assign port_int = ~intl_sync;

endmodule

// ==== rtl/board_core.sv ====
// Board management top level with UART host link, registers, GPIO and QSFP pins
module board_core #(
    parameter int CLKS_PER_BIT = 8,
    parameter int SW_CNT = 4,
    parameter int LED_CNT = 3,
    parameter int PORT_CNT = 2,
    parameter int DEBOUNCE_RATE = 4,
    parameter int DEBOUNCE_N = 4,
    parameter int RESET_CYCLES = 20
) (
    input  wire logic                clk,
    input  wire logic                reset,

    // GPIO
    input  wire logic [SW_CNT-1:0]   sw,
    output wire logic [LED_CNT-1:0]  led,

    // UART
    input  wire logic                uart_rxd,
    output wire logic                uart_txd,

    // QSFP management
    output wire logic [PORT_CNT-1:0] qsfp_modsell,
    output wire logic [PORT_CNT-1:0] qsfp_resetl,
    input  wire logic [PORT_CNT-1:0] qsfp_modprsl,
    input  wire logic [PORT_CNT-1:0] qsfp_intl,
    output wire logic [PORT_CNT-1:0] qsfp_lpmode
);

wire [SW_CNT-1:0] sw_int;
wire [board_pkg::REG_W-1:0] rx_data;
wire rx_valid;
wire [board_pkg::REG_W-1:0] tx_data;
wire tx_start;
wire tx_busy;

// Register handshake
wire reg_req;
wire reg_we;
wire [board_pkg::ADDR_W-1:0] reg_addr;
wire [board_pkg::REG_W-1:0] reg_wdata;
wire reg_ack;
wire [board_pkg::REG_W-1:0] reg_rdata;

wire [PORT_CNT-1:0] port_lpmode;
wire [PORT_CNT-1:0] port_sel;
wire [PORT_CNT-1:0] port_reset_start;
wire [PORT_CNT-1:0] port_in_reset;
wire [PORT_CNT-1:0] port_present;
wire [PORT_CNT-1:0] port_int;

debounce_switch #(
    .SW_CNT(SW_CNT),
    .DEBOUNCE_RATE(DEBOUNCE_RATE),
    .DEBOUNCE_N(DEBOUNCE_N)
)
debounce_switch_inst (
    .clk(clk),
    .reset(reset),
    .sw_in(sw),
    .sw_out(sw_int)
);

uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
)
uart_rx_inst (
    .clk(clk),
    .reset(reset),
    .rxd(uart_rxd),
    .rx_data(rx_data),
    .rx_valid(rx_valid)
);

uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
)
uart_tx_inst (
    .clk(clk),
    .reset(reset),
    .tx_data(tx_data),
    .tx_start(tx_start),
    .txd(uart_txd),
    .tx_busy(tx_busy)
);

mgmt_cmd
mgmt_cmd_inst (
    .clk(clk),
    .reset(reset),
    .rx_data(rx_data),
    .rx_valid(rx_valid),
    .reg_req(reg_req),
    .reg_we(reg_we),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_ack(reg_ack),
    .reg_rdata(reg_rdata),
    .tx_data(tx_data),
    .tx_start(tx_start),
    .tx_busy(tx_busy)
);

mgmt_regs #(
    .SW_CNT(SW_CNT),
    .LED_CNT(LED_CNT),
    .PORT_CNT(PORT_CNT)
)
mgmt_regs_inst (
    .clk(clk),
    .reset(reset),
    .reg_req(reg_req),
    .reg_we(reg_we),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_ack(reg_ack),
    .reg_rdata(reg_rdata),
    .sw_state(sw_int),
    .led(led),
    .port_lpmode(port_lpmode),
    .port_sel(port_sel),
    .port_reset_start(port_reset_start),
    .port_in_reset(port_in_reset),
    .port_present(port_present),
    .port_int(port_int)
);

qsfp_port_ctrl #(
    .PORT_CNT(PORT_CNT),
    .RESET_CYCLES(RESET_CYCLES)
)
qsfp_port_ctrl_inst (
    .clk(clk),
    .reset(reset),
    .port_lpmode(port_lpmode),
    .port_sel(port_sel),
    .port_reset_start(port_reset_start),
    .port_in_reset(port_in_reset),
    .port_present(port_present),
    .port_int(port_int),
    .qsfp_modsell(qsfp_modsell),
    .qsfp_resetl(qsfp_resetl),
    .qsfp_lpmode(qsfp_lpmode),
    .qsfp_modprsl(qsfp_modprsl),
    .qsfp_intl(qsfp_intl)
);

endmodule

// ==== sim/board_checker.sv ====
// Concurrent assertions on the register handshake and the QSFP reset pulse and their binds
module board_checker #(
    parameter int PORT_CNT = 2,
    parameter int RESET_CYCLES = 20
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           reg_req,
    input  wire logic                           reg_ack,
    input  wire logic [board_pkg::ADDR_W-1:0]   reg_addr,
    input  wire logic [board_pkg::REG_W-1:0]    reg_wdata,
    input  wire logic [PORT_CNT-1:0]            port_reset_start,
    input  wire logic [PORT_CNT-1:0]            qsfp_resetl
);

a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(reg_ack) |-> reg_req)
    else $error("reg_ack rose without reg_req");

a_req_after_ack: assert property (@(posedge clk) disable iff (reset)
    $rose(reg_req) |-> !reg_ack)
    else $error("reg_req rose while reg_ack was still high");

a_req_stable: assert property (@(posedge clk) disable iff (reset)
    ($past(reg_req) && reg_req) |-> ($stable(reg_addr) && $stable(reg_wdata)))
    else $error("reg_addr or reg_wdata changed during a request");

for (genvar p = 0; p < PORT_CNT; p++) begin : g_port
    a_pulse_start: assert property (@(posedge clk) disable iff (reset)
        $past(port_reset_start[p]) |-> !qsfp_resetl[p])
        else $error("Reset pulse on port %0d did not start", p);

    a_pulse_cause: assert property (@(posedge clk) disable iff (reset)
        $fell(qsfp_resetl[p]) |-> $past(port_reset_start[p]))
        else $error("Reset on port %0d fell without a start", p);

    // Pin releases exactly RESET_CYCLES after the last start
    a_pulse_len: assert property (@(posedge clk) disable iff (reset)
        $rose(qsfp_resetl[p]) |-> $past(port_reset_start[p], RESET_CYCLES + 1))
        else $error("Reset pulse on port %0d had the wrong length", p);
end

endmodule

bind mgmt_regs board_checker #(
    .PORT_CNT(PORT_CNT)
)
i_regs_checker (
    .clk(clk),
    .reset(reset),
    .reg_req(reg_req),
    .reg_ack(reg_ack),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    // Pulse side is watched by the port binding
    .port_reset_start('0),
    .qsfp_resetl('1)
);

bind qsfp_port_ctrl board_checker #(
    .PORT_CNT(PORT_CNT),
    .RESET_CYCLES(RESET_CYCLES)
)
i_port_checker (
    .clk(clk),
    .reset(reset),
    .reg_req(1'b0),
    .reg_ack(1'b0),
    .reg_addr('0),
    .reg_wdata('0),
    .port_reset_start(port_reset_start),
    .qsfp_resetl(qsfp_resetl)
);

// ==== sim/tb_board.sv ====
// Testbench for board_core with serial host model, register model and random stimulus
module tb_board;

localparam int CLKS_PER_BIT = 8;
localparam int SW_CNT = 4;
localparam int LED_CNT = 3;
localparam int PORT_CNT = 2;
localparam int DEBOUNCE_RATE = 4;
localparam int DEBOUNCE_N = 4;
localparam int RESET_CYCLES = 20;

localparam logic [7:0] LED_MASK = 8'((1 << LED_CNT) - 1);
localparam logic [7:0] PORT_MASK = 8'((1 << PORT_CNT) - 1);
localparam int PORT_MAX = (1 << PORT_CNT) - 1;

// Run length that sets the timeout
localparam int LOOPS = 8;
localparam int N_CMDS = 1 + 2 * LOOPS + 2 * LOOPS + 4 * LOOPS + 2 * LOOPS + 2 * LOOPS + LOOPS;
localparam int FRAME_CYCLES = 3 * 10 * CLKS_PER_BIT;
localparam int DEBOUNCE_WAIT = (DEBOUNCE_N + 1) * DEBOUNCE_RATE + 2;
localparam int RESET_WAIT = RESET_CYCLES + 4;
localparam int HOLD_CYCLES = 4;
localparam int WAIT_CYCLES = LOOPS * (RESET_WAIT + HOLD_CYCLES + DEBOUNCE_WAIT + DEBOUNCE_RATE);
localparam int CYCLE_LIMIT = 2 * (16 + N_CMDS * FRAME_CYCLES + WAIT_CYCLES);

logic clk;
logic reset;
logic [SW_CNT-1:0] sw;
wire [LED_CNT-1:0] led;
logic uart_rxd;
wire uart_txd;
wire [PORT_CNT-1:0] qsfp_modsell;
wire [PORT_CNT-1:0] qsfp_resetl;
wire [PORT_CNT-1:0] qsfp_lpmode;
logic [PORT_CNT-1:0] qsfp_modprsl;
logic [PORT_CNT-1:0] qsfp_intl;

// Register model
logic [7:0] model_led;
logic [7:0] model_lpmode;
logic [7:0] model_sel;

// Reset pins seen when a response start bit shows up
logic [PORT_CNT-1:0] resetl_at_start;

int cycle_cnt = 0;

board_core #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .SW_CNT(SW_CNT),
    .LED_CNT(LED_CNT),
    .PORT_CNT(PORT_CNT),
    .DEBOUNCE_RATE(DEBOUNCE_RATE),
    .DEBOUNCE_N(DEBOUNCE_N),
    .RESET_CYCLES(RESET_CYCLES)
)
i_dut (
    .clk(clk),
    .reset(reset),
    .sw(sw),
    .led(led),
    .uart_rxd(uart_rxd),
    .uart_txd(uart_txd),
    .qsfp_modsell(qsfp_modsell),
    .qsfp_resetl(qsfp_resetl),
    .qsfp_modprsl(qsfp_modprsl),
    .qsfp_intl(qsfp_intl),
    .qsfp_lpmode(qsfp_lpmode)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, the DUT stopped answering commands", cycle_cnt);
        $display("TESTS FAILED");
        $fatal(1);
    end
end

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

function automatic logic [7:0] cmd_byte(input logic [3:0] addr, input logic write);
    logic [7:0] cmd;
    cmd = 8'(addr) << board_pkg::CMD_ADDR_LSB;
    cmd[board_pkg::CMD_WRITE_BIT] = write;
    return cmd;
endfunction

// Expected read value from the register map rules
function automatic logic [7:0] model_read(input logic [3:0] addr);
    case (addr)
        board_pkg::ADDR_ID: return board_pkg::BOARD_ID;
        board_pkg::ADDR_SW: return 8'(sw);
        board_pkg::ADDR_LED: return model_led;
        board_pkg::ADDR_PORT_LPMODE: return model_lpmode;
        board_pkg::ADDR_PORT_SEL: return model_sel;
        board_pkg::ADDR_PORT_PRESENT: return 8'(~qsfp_modprsl) & PORT_MASK;
        board_pkg::ADDR_PORT_INT: return 8'(~qsfp_intl) & PORT_MASK;
        default: return 8'h00;
    endcase
endfunction

task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        uart_rxd <= frame[i];
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
endtask

task automatic recv_byte(output logic [7:0] data);
    @(negedge clk);
    while (uart_txd !== 1'b0) begin
        @(negedge clk);
    end
    resetl_at_start = qsfp_resetl;
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    check_value("uart_txd start bit", 8'(uart_txd), 8'h00);
    // Bit centres with the LSB first
    for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_txd;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("uart_txd stop bit", 8'(uart_txd), 8'h01);
    repeat (CLKS_PER_BIT / 2 + 1) @(negedge clk);
endtask

task automatic do_read(input logic [3:0] addr);
    logic [7:0] exp;
    logic [7:0] got;
    exp = model_read(addr);
    send_byte(cmd_byte(addr, 1'b0));
    recv_byte(got);
    check_value($sformatf("uart_txd response to read at %h", addr), got, exp);
endtask

task automatic do_write(input logic [3:0] addr, input logic [7:0] wdata);
    logic [7:0] exp;
    logic [7:0] got;
    case (addr)
        board_pkg::ADDR_LED: model_led = wdata & LED_MASK;
        board_pkg::ADDR_PORT_LPMODE: model_lpmode = wdata & PORT_MASK;
        board_pkg::ADDR_PORT_SEL: model_sel = wdata & PORT_MASK;
        default: ;
    endcase
    // Reset register answers with the ports just put into reset
    if (addr == board_pkg::ADDR_PORT_RESET) begin
        exp = wdata & PORT_MASK;
    end else begin
        exp = model_read(addr);
    end
    send_byte(cmd_byte(addr, 1'b1));
    send_byte(wdata);
    recv_byte(got);
    check_value($sformatf("uart_txd response to write of %h at %h", wdata, addr), got, exp);
endtask

initial begin
    int unsigned seed_val;
    logic [3:0] addr;
    logic [7:0] val;
    logic [SW_CNT-1:0] sw_val;

    seed_val = $urandom(91);
    reset = 1'b1;
    sw = '0;
    uart_rxd = 1'b1;
    qsfp_modprsl = '1;
    qsfp_intl = '1;
    model_led = 8'h00;
    model_lpmode = 8'h00;
    model_sel = 8'h00;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Idle state of the pins
    @(negedge clk);
    check_value("uart_txd", 8'(uart_txd), 8'h01);
    check_value("led", 8'(led), 8'h00);
    check_value("qsfp_lpmode", 8'(qsfp_lpmode), 8'h00);
    check_value("qsfp_modsell", 8'(qsfp_modsell), PORT_MASK);
    check_value("qsfp_resetl", 8'(qsfp_resetl), PORT_MASK);

    // ID and unmapped addresses
    do_read(board_pkg::ADDR_ID);
    for (int i = 0; i < LOOPS; i++) begin
        addr = 4'(8 + $urandom_range(7));
        do_read(addr);
        do_write(addr, 8'($urandom));
    end

    // LEDs
    for (int i = 0; i < LOOPS; i++) begin
        val = 8'($urandom);
        do_write(board_pkg::ADDR_LED, val);
        check_value("led", 8'(led), model_led);
        do_read(board_pkg::ADDR_LED);
    end

    // Low-power mode and module select
    for (int i = 0; i < LOOPS; i++) begin
        do_write(board_pkg::ADDR_PORT_LPMODE, 8'($urandom));
        do_write(board_pkg::ADDR_PORT_SEL, 8'($urandom));
        check_value("qsfp_lpmode", 8'(qsfp_lpmode), model_lpmode);
        check_value("qsfp_modsell", 8'(qsfp_modsell), ~model_sel & PORT_MASK);
        do_read(board_pkg::ADDR_PORT_LPMODE);
        do_read(board_pkg::ADDR_PORT_SEL);
    end

    // Timed module reset
    for (int i = 0; i < LOOPS; i++) begin
        val = 8'($urandom_range(PORT_MAX, 1));
        do_write(board_pkg::ADDR_PORT_RESET, val);
        check_value("qsfp_resetl", 8'(resetl_at_start), ~val & PORT_MASK);
        repeat (RESET_WAIT) @(negedge clk);
        check_value("qsfp_resetl", 8'(qsfp_resetl), PORT_MASK);
        do_read(board_pkg::ADDR_PORT_RESET);
    end

    // Presence and interrupt status
    for (int i = 0; i < LOOPS; i++) begin
        @(posedge clk);
        qsfp_modprsl <= PORT_CNT'($urandom);
        qsfp_intl <= PORT_CNT'($urandom);
        repeat (HOLD_CYCLES) @(posedge clk);
        do_read(board_pkg::ADDR_PORT_PRESENT);
        do_read(board_pkg::ADDR_PORT_INT);
    end

    // Switches with each new value led by a short glitch
    for (int i = 0; i < LOOPS; i++) begin
        sw_val = SW_CNT'($urandom);
        @(posedge clk);
        sw <= SW_CNT'($urandom);
        repeat (DEBOUNCE_RATE - 1) @(posedge clk);
        sw <= sw_val;
        repeat (DEBOUNCE_WAIT) @(posedge clk);
        do_read(board_pkg::ADDR_SW);
    end

    $display("TESTS PASSED");
    $finish;
end

endmodule

// ==== vlog.f ====
rtl/board_pkg.sv
rtl/debounce_switch.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/mgmt_cmd.sv
rtl/mgmt_regs.sv
rtl/qsfp_port_ctrl.sv
rtl/board_core.sv
sim/board_checker.sv
sim/tb_board.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_board -f vlog.f -o tb_board_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_board_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
